// File: src/ctrl_pkg.sv
package ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Paddle charge timing
	////////////////////////////////////////////////////////////////////////////

	// Charge cycles until a paddle line counts as dumped
	localparam int INPUT_CYCLES = 256;
	localparam int CTR_W        = 9;

	////////////////////////////////////////////////////////////////////////////
	// Scan sequencer
	////////////////////////////////////////////////////////////////////////////

	localparam int SCAN_PERIOD = 512;
	localparam int SCAN_W      = 9;

	////////////////////////////////////////////////////////////////////////////
	// Credit links
	////////////////////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH   = 4;
	localparam int PTR_W        = 2;
	// Matches the console-side receive buffer
	localparam int LINK_CREDITS = 2;
	localparam int CREDIT_W     = 3;

	// RIOT port snapshot
	typedef struct packed {
		logic [7:0] pa;
		logic [7:0] pb;
	} port_word_t;

	// TIA input flags snapshot
	typedef struct packed {
		logic [3:0] idump;
		logic [1:0] ilatch;
		logic [1:0] two_button;
	} paddle_word_t;

endpackage

// File: src/paddle_charge_timer.sv
module paddle_charge_timer (
	input  logic       pclk_0,
	input  logic       rst_n,
	input  logic [3:0] paddle_lines,
	output logic [3:0] idump
);

	// One charge counter per paddle lane, order {A0, B0, A1, B1}
	logic [ctrl_pkg::CTR_W-1:0] charge_ctr [4];

	localparam logic [ctrl_pkg::CTR_W-1:0] DUMP_LEVEL = ctrl_pkg::CTR_W'(ctrl_pkg::INPUT_CYCLES);

	////////////////////////////////////////////////////////////////////////////
	// Charge counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				charge_ctr[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				// Capacitor discharged while the line is held low
				if (!paddle_lines[i]) begin
					charge_ctr[i] <= '0;
				end else if (charge_ctr[i] < DUMP_LEVEL) begin
					charge_ctr[i] <= charge_ctr[i] + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Dump flags
	////////////////////////////////////////////////////////////////////////////

	// Lane is dumped once its counter has saturated
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			idump[i] = (charge_ctr[i] == DUMP_LEVEL);
		end
	end

endmodule

// File: src/port_mapper.sv
module port_mapper (
	input  logic       pclk_0,
	input  logic       rst_n,
	input  logic [6:0] ctrl_0,
	input  logic [6:0] ctrl_1,
	input  logic [1:0] sw,
	input  logic       pb_up,
	input  logic       pb_down,
	input  logic       pb_left,
	output logic [7:0] pa,
	output logic [7:0] pb,
	output logic [3:0] paddle_lines
);

	// Pins that need synchronizing; bit 5 of each connector is not wired
	localparam int PIN_W = 17;

	logic [PIN_W-1:0] pins_raw;
	logic [PIN_W-1:0] pins_meta;
	logic [PIN_W-1:0] pins_sync;

	logic [3:0] joy_0;
	logic [3:0] joy_1;
	logic [1:0] sw_s;
	logic       pb_up_s;
	logic       pb_down_s;
	logic       pb_left_s;

	assign pins_raw = {ctrl_0[6], ctrl_0[4], ctrl_1[6], ctrl_1[4],
		ctrl_0[3:0], ctrl_1[3:0], sw, pb_down, pb_left, pb_up};

	////////////////////////////////////////////////////////////////////////////
	// Two-flop synchronizer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			pins_meta <= '0;
			pins_sync <= '0;
		end else begin
			pins_meta <= pins_raw;
			pins_sync <= pins_meta;
		end
	end

	assign {paddle_lines, joy_0, joy_1, sw_s, pb_down_s, pb_left_s, pb_up_s} = pins_sync;

	////////////////////////////////////////////////////////////////////////////
	// RIOT port words
	////////////////////////////////////////////////////////////////////////////

	// Joysticks: right, left, down, up, all active low
	assign pa = {joy_0, joy_1};

	// Difficulty switches on top, panel buttons inverted
	assign pb[7] = sw_s[1];
	assign pb[6] = sw_s[0];
	assign pb[5] = 1'b0;
	assign pb[4] = 1'b0;
	assign pb[3] = ~pb_down_s;  // pause
	assign pb[2] = 1'b0;
	assign pb[1] = ~pb_left_s;  // select
	assign pb[0] = ~pb_up_s;    // reset

endmodule

// File: src/scan_sequencer.sv
module scan_sequencer (
	input  logic                   pclk_0,
	input  logic                   rst_n,
	input  logic [7:0]             pa,
	input  logic [7:0]             pb,
	input  logic [3:0]             idump,
	input  logic                   tia_en,
	input  logic [7:0]             pb_out,
	input  logic                   port_full,
	input  logic                   pad_full,
	output logic                   port_push,
	output logic                   pad_push,
	output ctrl_pkg::port_word_t   port_snap,
	output ctrl_pkg::paddle_word_t pad_snap,
	output logic [7:0]             drop_count
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_CHECK,
		S_PUSH,
		S_DROP
	} scan_state_t;

	// Enter CHECK so that it coincides with the counter at SCAN_PERIOD-1
	localparam logic [ctrl_pkg::SCAN_W-1:0] PRE_TICK = ctrl_pkg::SCAN_W'(ctrl_pkg::SCAN_PERIOD - 2);

	scan_state_t                state;
	scan_state_t                state_nxt;
	logic [ctrl_pkg::SCAN_W-1:0] interval_ctr;
	logic                       tick;
	logic                       accept;
	logic [1:0]                 ilatch;
	logic [1:0]                 two_button;

	////////////////////////////////////////////////////////////////////////////
	// Interval counter
	////////////////////////////////////////////////////////////////////////////

	// Wraps naturally every SCAN_PERIOD cycles
	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			interval_ctr <= '0;
		end else begin
			interval_ctr <= interval_ctr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Scan FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (interval_ctr == PRE_TICK) begin
					state_nxt = S_CHECK;
				end
			end
			S_CHECK: state_nxt = accept ? S_PUSH : S_DROP;
			S_PUSH:  state_nxt = S_IDLE;
			S_DROP:  state_nxt = S_IDLE;
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Both links must have room, else the whole snapshot is lost
	assign tick   = (state == S_CHECK);
	assign accept = !port_full && !pad_full;

	assign port_push = tick && accept;
	assign pad_push  = tick && accept;

	// Saturating drop counter
	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			drop_count <= '0;
		end else if (state == S_DROP && drop_count != 8'hff) begin
			drop_count <= drop_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Snapshot words
	////////////////////////////////////////////////////////////////////////////

	// Fire latch reads one when neither paddle of the connector is dumped
	assign ilatch[0] = ~idump[3] & ~idump[2];
	assign ilatch[1] = ~idump[1] & ~idump[0];

	assign two_button[0] = ~pb_out[2] & ~tia_en;
	assign two_button[1] = ~pb_out[4] & ~tia_en;

	assign port_snap.pa = pa;
	assign port_snap.pb = pb;

	assign pad_snap.idump      = idump;
	assign pad_snap.ilatch     = ilatch;
	assign pad_snap.two_button = two_button;

endmodule

// File: src/credit_link_fifo.sv
module credit_link_fifo #(
	parameter type payload_t = ctrl_pkg::port_word_t
) (
	input  logic     pclk_0,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	output logic     full,
	output logic     tx_valid,
	output payload_t tx_data,
	input  logic     credit
);

	localparam logic [ctrl_pkg::CREDIT_W-1:0] DEPTH_C   = ctrl_pkg::CREDIT_W'(ctrl_pkg::FIFO_DEPTH);
	localparam logic [ctrl_pkg::CREDIT_W-1:0] CREDITS_C = ctrl_pkg::CREDIT_W'(ctrl_pkg::LINK_CREDITS);

	payload_t                      mem [ctrl_pkg::FIFO_DEPTH];
	logic [ctrl_pkg::PTR_W-1:0]    wr_ptr;
	logic [ctrl_pkg::PTR_W-1:0]    rd_ptr;
	logic [ctrl_pkg::CREDIT_W-1:0] occupancy;
	logic [ctrl_pkg::CREDIT_W-1:0] credits;
	logic                          wr_en;
	logic                          fire;

	assign full  = (occupancy == DEPTH_C);
	assign wr_en = push && !full;

	// Beat goes out when an item is waiting and the receiver has room
	assign fire = (occupancy != '0) && (credits != '0);

	assign tx_valid = fire;
	assign tx_data  = mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Buffer storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pclk_0) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (fire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Emit in the same cycle frees space only after the edge
			case ({wr_en, fire})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sender credit counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CREDITS_C;
		end else begin
			case ({fire, credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// File: src/input_ctrl_top.sv
module input_ctrl_top (
	input  logic                   pclk_0,
	input  logic                   rst_n,
	input  logic [6:0]             ctrl_0,
	input  logic [6:0]             ctrl_1,
	input  logic [1:0]             sw,
	input  logic                   pb_up,
	input  logic                   pb_down,
	input  logic                   pb_left,
	input  logic                   tia_en,
	input  logic [7:0]             pb_out,
	output logic                   port_valid,
	output ctrl_pkg::port_word_t   port_data,
	input  logic                   port_credit,
	output logic                   pad_valid,
	output ctrl_pkg::paddle_word_t pad_data,
	input  logic                   pad_credit,
	output logic [7:0]             drop_count
);

	logic [7:0] pa;
	logic [7:0] pb;
	logic [3:0] paddle_lines;
	logic [3:0] idump;

	logic                   port_push;
	logic                   pad_push;
	logic                   port_full;
	logic                   pad_full;
	ctrl_pkg::port_word_t   port_snap;
	ctrl_pkg::paddle_word_t pad_snap;

	////////////////////////////////////////////////////////////////////////////
	// Pin capture and paddle timing
	////////////////////////////////////////////////////////////////////////////

	port_mapper mapper (
		.pclk_0       (pclk_0),
		.rst_n        (rst_n),
		.ctrl_0       (ctrl_0),
		.ctrl_1       (ctrl_1),
		.sw           (sw),
		.pb_up        (pb_up),
		.pb_down      (pb_down),
		.pb_left      (pb_left),
		.pa           (pa),
		.pb           (pb),
		.paddle_lines (paddle_lines)
	);

	paddle_charge_timer timer (
		.pclk_0       (pclk_0),
		.rst_n        (rst_n),
		.paddle_lines (paddle_lines),
		.idump        (idump)
	);

	////////////////////////////////////////////////////////////////////////////
	// Snapshot capture
	////////////////////////////////////////////////////////////////////////////

	scan_sequencer sequencer (
		.pclk_0     (pclk_0),
		.rst_n      (rst_n),
		.pa         (pa),
		.pb         (pb),
		.idump      (idump),
		.tia_en     (tia_en),
		.pb_out     (pb_out),
		.port_full  (port_full),
		.pad_full   (pad_full),
		.port_push  (port_push),
		.pad_push   (pad_push),
		.port_snap  (port_snap),
		.pad_snap   (pad_snap),
		.drop_count (drop_count)
	);

	// Links to the console core
	credit_link_fifo #(.payload_t(ctrl_pkg::port_word_t)) port_link (
		.pclk_0    (pclk_0),
		.rst_n     (rst_n),
		.push      (port_push),
		.push_data (port_snap),
		.full      (port_full),
		.tx_valid  (port_valid),
		.tx_data   (port_data),
		.credit    (port_credit)
	);

	credit_link_fifo #(.payload_t(ctrl_pkg::paddle_word_t)) pad_link (
		.pclk_0    (pclk_0),
		.rst_n     (rst_n),
		.push      (pad_push),
		.push_data (pad_snap),
		.full      (pad_full),
		.tx_valid  (pad_valid),
		.tx_data   (pad_data),
		.credit    (pad_credit)
	);

endmodule

// File: tb/tb_input_ctrl_sva.sv
module tb_input_ctrl_sva (
	input logic                          pclk_0,
	input logic                          rst_n,
	input logic                          tx_valid,
	input logic                          credit,
	input logic [ctrl_pkg::CREDIT_W-1:0] credits
);

	timeunit 1ns;
	timeprecision 100ps;

	// Receiver buffer slots still free, seen from beats and returned credits
	int granted;

	always_ff @(posedge pclk_0 or negedge rst_n) begin
		if (!rst_n) begin
			granted <= ctrl_pkg::LINK_CREDITS;
		end else begin
			granted <= granted - int'(tx_valid) + int'(credit);
		end
	end

	// Sampled mid-cycle, where beats and the credit count are settled
	beat_needs_credit: assert property (@(negedge pclk_0) disable iff (!rst_n)
		tx_valid |-> (granted > 0))
		else $error("beat issued with no credit held");

	credit_bound: assert property (@(negedge pclk_0) disable iff (!rst_n)
		int'(credits) <= ctrl_pkg::LINK_CREDITS)
		else $error("credit count above the receiver buffer size");

	quiet_in_reset: assert property (@(negedge pclk_0)
		!rst_n |-> !tx_valid)
		else $error("valid high while in reset");

endmodule

// One checker per link FIFO
bind credit_link_fifo tb_input_ctrl_sva link_checks (
	.pclk_0   (pclk_0),
	.rst_n    (rst_n),
	.tx_valid (tx_valid),
	.credit   (credit),
	.credits  (credits)
);

// File: tb/tb_input_ctrl.sv
module tb_input_ctrl;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_PERIODS = 24;
	localparam int STALL_LIMIT = 3;
	localparam int DRAIN_LIMIT = 64;

	logic                   pclk_0;
	logic                   rst_n;
	logic [6:0]             ctrl_0;
	logic [6:0]             ctrl_1;
	logic [1:0]             sw;
	logic                   pb_up;
	logic                   pb_down;
	logic                   pb_left;
	logic                   tia_en;
	logic [7:0]             pb_out;
	logic                   port_valid;
	ctrl_pkg::port_word_t   port_data;
	logic                   port_credit;
	logic                   pad_valid;
	ctrl_pkg::paddle_word_t pad_data;
	logic                   pad_credit;
	logic [7:0]             drop_count;

	// Reference model state
	ctrl_pkg::port_word_t   port_q [$];
	ctrl_pkg::paddle_word_t pad_q [$];
	logic [3:0]             exp_dump;
	logic [7:0]             exp_drops = 8'h00;
	int                     raise_at [4];
	int                     scan_pos = 0;
	int                     port_cred = ctrl_pkg::LINK_CREDITS;
	int                     pad_cred = ctrl_pkg::LINK_CREDITS;
	int                     port_owed = 0;
	int                     pad_owed = 0;
	int                     port_stall = 0;
	int                     pad_stall = 0;
	int                     port_hold = 0;
	int                     pad_hold = 0;
	int                     wait_cnt;
	logic                   tick;
	logic                   accept;
	logic                   withhold;
	logic                   draining;

	input_ctrl_top uut (.*);

	always #50 pclk_0 = ~pclk_0;

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_failed();
		$display("STATUS: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR: %s", msg);
		stop_failed();
	endtask

	task automatic check_port(input ctrl_pkg::port_word_t exp, input ctrl_pkg::port_word_t got);
		if (got !== exp) begin
			$display("MISMATCH port_data: expected %h, got %h", exp, got);
			stop_failed();
		end
	endtask

	task automatic check_pad(input ctrl_pkg::paddle_word_t exp,
		input ctrl_pkg::paddle_word_t got);
		if (got !== exp) begin
			$display("MISMATCH pad_data: expected %h, got %h", exp, got);
			stop_failed();
		end
	endtask

	task automatic check_drops(input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			$display("MISMATCH drop_count: expected %h, got %h", exp, got);
			stop_failed();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("MISMATCH %s: expected %h, got %h", name, exp, got);
			stop_failed();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected snapshot words
	////////////////////////////////////////////////////////////////////////////

	function automatic ctrl_pkg::port_word_t expect_port();
		ctrl_pkg::port_word_t w;
		w.pa = {ctrl_0[3:0], ctrl_1[3:0]};
		w.pb = {sw[1], sw[0], 2'b00, ~pb_down, 1'b0, ~pb_left, ~pb_up};
		return w;
	endfunction

	function automatic ctrl_pkg::paddle_word_t expect_pad();
		ctrl_pkg::paddle_word_t w;
		w.idump         = exp_dump;
		w.ilatch[0]     = !exp_dump[3] && !exp_dump[2];
		w.ilatch[1]     = !exp_dump[1] && !exp_dump[0];
		w.two_button[0] = !pb_out[2] && !tia_en;
		w.two_button[1] = !pb_out[4] && !tia_en;
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Lane order {A0, B0, A1, B1}, paddle A on bit 6 and B on bit 4
	task automatic set_lane(input int lane, input logic level);
		case (lane)
			3:       ctrl_0[6] = level;
			2:       ctrl_0[4] = level;
			1:       ctrl_1[6] = level;
			default: ctrl_1[4] = level;
		endcase
	endtask

	task automatic start_period();
		int mode;
		ctrl_0  = 7'($urandom());
		ctrl_1  = 7'($urandom());
		sw      = 2'($urandom());
		pb_up   = 1'($urandom());
		pb_down = 1'($urandom());
		pb_left = 1'($urandom());
		tia_en  = 1'($urandom());
		pb_out  = 8'($urandom());
		for (int i = 0; i < 4; i++) begin
			mode        = int'($urandom_range(3, 0));
			raise_at[i] = 0;
			set_lane(i, mode == 1);
			exp_dump[i] = (mode == 1) || (mode == 2);
			// Early rise leaves 300+ cycles of charge, late rise 200 or less
			if (mode == 2) raise_at[i] = int'($urandom_range(200, 1));
			if (mode == 3) raise_at[i] = int'($urandom_range(500, 320));
		end
	endtask

	task automatic run_period(input int index);
		withhold = (index >= 8) && (index < 16);
		draining = (index == NUM_PERIODS - 1);
		start_period();
		for (int c = 1; c < ctrl_pkg::SCAN_PERIOD; c++) begin
			@(posedge pclk_0);
			#1;
			for (int i = 0; i < 4; i++) begin
				if (raise_at[i] == c) set_lane(i, 1'b1);
			end
		end
		@(posedge pclk_0);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Consumer and reference model
	////////////////////////////////////////////////////////////////////////////

	// Mostly short credit delays, now and then a long stall
	function automatic int pick_delay();
		if (draining) return 0;
		if ($urandom_range(9, 0) == 0) return int'($urandom_range(2000, 600));
		return int'($urandom_range(12, 0));
	endfunction

	always @(posedge pclk_0) begin
		#1;
		port_credit = 1'b0;
		pad_credit  = 1'b0;
		if (draining) begin
			port_hold = 0;
			pad_hold  = 0;
		end
		if (rst_n && !withhold) begin
			if (port_hold > 0) begin
				port_hold--;
			end else if (port_owed > 0) begin
				port_credit = 1'b1;
				port_owed--;
				port_hold = pick_delay();
			end
			if (pad_hold > 0) begin
				pad_hold--;
			end else if (pad_owed > 0) begin
				pad_credit = 1'b1;
				pad_owed--;
				pad_hold = pick_delay();
			end
		end
	end

	always @(negedge pclk_0) begin
		if (!rst_n) begin
			check_flag("port_valid", 1'b0, port_valid);
			check_flag("pad_valid", 1'b0, pad_valid);
			check_drops(8'h00, drop_count);
		end else begin
			tick   = (scan_pos == ctrl_pkg::SCAN_PERIOD - 1);
			// Room is judged before this cycle's beats leave
			accept = (port_q.size() < ctrl_pkg::FIFO_DEPTH) && (pad_q.size() < ctrl_pkg::FIFO_DEPTH);
			if (tick) check_drops(exp_drops, drop_count);
			if (port_valid) begin
				if (port_cred == 0) report_failure("port link sent a beat with no credit held");
				else if (port_q.size() == 0) report_failure("port link sent an item never captured");
				else check_port(port_q.pop_front(), port_data);
				port_cred--;
				port_owed++;
				port_stall = 0;
			end else if (port_q.size() != 0 && port_cred != 0) begin
				port_stall++;
				if (port_stall > STALL_LIMIT) report_failure("port beat timed out with a credit held");
			end
			if (pad_valid) begin
				if (pad_cred == 0) report_failure("paddle link sent a beat with no credit held");
				else if (pad_q.size() == 0) report_failure("paddle link sent an item never captured");
				else check_pad(pad_q.pop_front(), pad_data);
				pad_cred--;
				pad_owed++;
				pad_stall = 0;
			end else if (pad_q.size() != 0 && pad_cred != 0) begin
				pad_stall++;
				if (pad_stall > STALL_LIMIT) report_failure("paddle beat timed out with a credit held");
			end
			if (port_credit) port_cred++;
			if (pad_credit) pad_cred++;
			if (tick && accept) begin
				port_q.push_back(expect_port());
				pad_q.push_back(expect_pad());
			end else if (tick && exp_drops != 8'hff) begin
				exp_drops = exp_drops + 8'd1;
			end
			scan_pos = (scan_pos + 1) % ctrl_pkg::SCAN_PERIOD;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h818c));
		pclk_0      = 1'b0;
		rst_n       = 1'b0;
		ctrl_0      = 7'h7f;
		ctrl_1      = 7'h7f;
		sw          = 2'b00;
		pb_up       = 1'b0;
		pb_down     = 1'b0;
		pb_left     = 1'b0;
		tia_en      = 1'b1;
		pb_out      = 8'h00;
		port_credit = 1'b0;
		pad_credit  = 1'b0;
		withhold    = 1'b0;
		draining    = 1'b0;
		repeat (2) @(posedge pclk_0);
		#1;
		rst_n = 1'b1;
		for (int p = 0; p < NUM_PERIODS; p++) begin
			run_period(p);
		end
		wait_cnt = 0;
		while ((port_q.size() != 0 || pad_q.size() != 0) && wait_cnt < DRAIN_LIMIT) begin
			@(posedge pclk_0);
			wait_cnt++;
		end
		if (port_q.size() != 0 || pad_q.size() != 0) begin
			report_failure("links did not drain after credits were released");
		end
		check_drops(exp_drops, drop_count);
		if (exp_drops == 8'h00) begin
			report_failure("no snapshot was dropped while credits were withheld");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

// File: sim.f
src/ctrl_pkg.sv
src/paddle_charge_timer.sv
src/port_mapper.sv
src/scan_sequencer.sv
src/credit_link_fifo.sv
src/input_ctrl_top.sv
tb/tb_input_ctrl_sva.sv
tb/tb_input_ctrl.sv

// File: Makefile
SIM      := verilator
TOP      := tb_input_ctrl
FILELIST := sim.f
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
